/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_decode
FILELIST  := rv_decode.f

BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard src/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* rv_decode.f */
+incdir+testbench
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/inst_latch.sv
src/hazard_check.sv
src/inst_decoder.sv
src/next_pc_unit.sv
src/decode_stage.sv
testbench/decode_chk.sv
testbench/decode_monitor.sv
testbench/tb_decode.sv

/* src/decode_pkg.sv */
// bundle layouts shared by the decode stage; field order is fixed by the packed structs
package decode_pkg;
  import rv_isa_pkg::*;

  // writeback source for the destination register
  typedef enum logic [1:0] {
    WD_ALU, WD_LOAD, WD_PC4, WD_CSR
  } wd_sel_e;

  // next-pc source
  typedef enum logic [1:0] {
    PC_SEQ, PC_REL, PC_JALR, PC_CSR
  } pc_sel_e;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
  } fetch_bundle_t;

  // one in-flight destination
  typedef struct packed {
    logic        busy;
    logic [4:0]  rd;
    csr_idx_e    csr_rd;
    logic        csr_wr;
  } dest_tag_t;

  typedef struct packed {
    alu_op_e     alu_op;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [4:0]  rd;
    csr_idx_e    csr_rd;
    logic        reg_wr;
    logic        csr_wr;
    logic        csr_wd_pc;
    wd_sel_e     wd_sel;
    logic        mem_rd;
    logic        mem_wr;
    logic [3:0]  wmask;
    logic [1:0]  rsize;
    logic        rsigned;
    logic        ecall;
    logic        ebreak;
  } decode_ctrl_t;

endpackage

/* src/decode_stage.sv */
// register file and CSR data must return combinationally for the addresses driven out
`timescale 1ns/10ps

module decode_stage import rv_isa_pkg::*, decode_pkg::*; #(
  parameter int N_STAGES = 3
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          in_valid,
  input  fetch_bundle_t in_bundle,
  output logic          in_ready,
  input  dest_tag_t     tags [N_STAGES],
  output logic [4:0]    rs1_addr,
  output logic [4:0]    rs2_addr,
  output csr_idx_e      csr_src,
  input  logic [31:0]   rs1_data,
  input  logic [31:0]   rs2_data,
  input  logic [31:0]   csr_data,
  output logic          out_valid,
  input  logic          out_ready,
  output decode_ctrl_t  ctrl,
  output logic [31:0]   pc,
  output logic [31:0]   next_pc,
  output logic          pc_write
);

  fetch_bundle_t held;
  logic          full;
  logic          stall;
  pc_sel_e       pc_sel;
  logic [2:0]    br_funct;
  logic          is_branch;

  assign rs1_addr = full ? held.inst[19:15] : 5'd0;
  assign rs2_addr = full ? held.inst[24:20] : 5'd0;
  assign pc       = held.pc;

  inst_latch u_latch (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_bundle (in_bundle),
    .in_ready  (in_ready),
    .stall     (stall),
    .out_ready (out_ready),
    .held      (held),
    .full      (full),
    .out_valid (out_valid),
    .accept    (pc_write)
  );

  hazard_check #(
    .N_STAGES (N_STAGES)
  ) u_hazard (
    .inst    (held.inst),
    .tags    (tags),
    .csr_src (csr_src),
    .stall   (stall)
  );

  inst_decoder u_decoder (
    .inst      (held.inst),
    .pc        (held.pc),
    .csr_src   (csr_src),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .csr_data  (csr_data),
    .ctrl      (ctrl),
    .pc_sel    (pc_sel),
    .br_funct  (br_funct),
    .is_branch (is_branch)
  );

  next_pc_unit u_next_pc (
    .pc        (held.pc),
    .ctrl      (ctrl),
    .pc_sel    (pc_sel),
    .br_funct  (br_funct),
    .is_branch (is_branch),
    .csr_data  (csr_data),
    .next_pc   (next_pc)
  );

endmodule

/* src/hazard_check.sv */
// sources are compared whatever the format, so unused rs fields may stall conservatively
`timescale 1ns/10ps

module hazard_check import rv_isa_pkg::*, decode_pkg::*; #(
  parameter int N_STAGES = 3
) (
  input  logic [31:0] inst,
  input  dest_tag_t   tags [N_STAGES],
  output csr_idx_e    csr_src,
  output logic        stall
);

  logic [4:0] rs1;
  logic [4:0] rs2;

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // ecall and mret read a fixed CSR, everything else the encoded one
  assign csr_src = (inst == INST_ECALL) ? CSR_MCAUSE :
                   (inst == INST_MRET)  ? CSR_MEPC   : csr_map(inst[31:20]);

  always_comb begin
    stall = 1'b0;
    for (int i = 0; i < N_STAGES; i++) begin
      if (tags[i].busy) begin
        // x0 is never a real dependency
        if ((tags[i].rd != 5'd0) && ((tags[i].rd == rs1) || (tags[i].rd == rs2)))
          stall = 1'b1;
        if (tags[i].csr_wr && (tags[i].csr_rd == csr_src))
          stall = 1'b1;
      end
    end
  end

endmodule

/* src/inst_decoder.sv */
// mulh and mulhsu are not supported and decode as add; unknown opcodes fall to I format
`timescale 1ns/10ps

module inst_decoder import rv_isa_pkg::*, decode_pkg::*; (
  input  logic [31:0]  inst,
  input  logic [31:0]  pc,
  input  csr_idx_e     csr_src,
  input  logic [31:0]  rs1_data,
  input  logic [31:0]  rs2_data,
  input  logic [31:0]  csr_data,
  output decode_ctrl_t ctrl,
  output pc_sel_e      pc_sel,
  output logic [2:0]   br_funct,
  output logic         is_branch
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  inst_fmt_e   fmt;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] imm_s;
  logic [31:0] imm_j;
  logic [31:0] imm_b;
  logic [31:0] imm_csr;
  logic [31:0] imm;
  alu_op_e     alu_op;
  logic        is_ecall;
  logic        is_mret;
  logic        is_csrrw;
  logic        is_csrrs;
  logic        is_store;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign is_ecall  = (inst == INST_ECALL);
  assign is_mret   = (inst == INST_MRET);
  assign is_csrrw  = (opcode == OPC_SYSTEM) && (funct3 == F3_CSRRW);
  assign is_csrrs  = (opcode == OPC_SYSTEM) && (funct3 == F3_CSRRS);
  assign is_store  = (opcode == OPC_STORE);
  assign is_branch = (opcode == OPC_BRANCH);
  assign br_funct  = funct3;

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC:                fmt = FMT_U;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:    fmt = FMT_I;
      OPC_JAL:                           fmt = FMT_J;
      OPC_STORE:                         fmt = FMT_S;
      OPC_OP:                            fmt = FMT_R;
      OPC_BRANCH:                        fmt = FMT_B;
      OPC_SYSTEM:                        fmt = FMT_SYS;
      default:                           fmt = FMT_I;
    endcase
  end

  // sign-extended immediates per format
  assign imm_i   = {{20{inst[31]}}, inst[31:20]};
  assign imm_u   = {inst[31:12], 12'b0};
  assign imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_csr = {20'b0, inst[31:20]};

  always_comb begin
    case (fmt)
      FMT_I:   imm = imm_i;
      FMT_U:   imm = imm_u;
      FMT_S:   imm = imm_s;
      FMT_J:   imm = imm_j;
      FMT_B:   imm = imm_b;
      FMT_SYS: imm = imm_csr;
      default: imm = 32'd0;
    endcase
  end

  always_comb begin
    alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: alu_op = ALU_IMM;
      OPC_OP: begin
        case ({funct7, funct3})
          {F7_BASE, 3'b000}:   alu_op = ALU_ADD;
          {F7_ALT, 3'b000}:    alu_op = ALU_SUB;
          {F7_BASE, 3'b001}:   alu_op = ALU_SLL;
          {F7_BASE, 3'b010}:   alu_op = ALU_SLT;
          {F7_BASE, 3'b011}:   alu_op = ALU_SLTU;
          {F7_BASE, 3'b100}:   alu_op = ALU_XOR;
          {F7_BASE, 3'b101}:   alu_op = ALU_SRL;
          {F7_ALT, 3'b101}:    alu_op = ALU_SRA;
          {F7_BASE, 3'b110}:   alu_op = ALU_OR;
          {F7_BASE, 3'b111}:   alu_op = ALU_AND;
          {F7_MULDIV, 3'b000}: alu_op = ALU_MUL;
          {F7_MULDIV, 3'b011}: alu_op = ALU_MULHU;
          {F7_MULDIV, 3'b100}: alu_op = ALU_DIV;
          {F7_MULDIV, 3'b101}: alu_op = ALU_DIVU;
          {F7_MULDIV, 3'b110}: alu_op = ALU_REM;
          {F7_MULDIV, 3'b111}: alu_op = ALU_REMU;
          default:             alu_op = ALU_ADD;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          // srai carries bit 30
          3'b101:  alu_op = inst[30] ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      OPC_BRANCH: begin
        case (funct3)
          F3_BLT, F3_BGE:   alu_op = ALU_SLT;
          F3_BLTU, F3_BGEU: alu_op = ALU_SLTU;
          default:          alu_op = ALU_SUB;
        endcase
      end
      OPC_SYSTEM: begin
        if (is_csrrs)
          alu_op = ALU_CSR_OR;
        else if (is_csrrw)
          alu_op = ALU_CSR_SRC;
      end
      default: alu_op = ALU_ADD;
    endcase
  end

  always_comb begin
    ctrl.alu_op = alu_op;
    ctrl.imm    = imm;
    ctrl.src1   = ((opcode == OPC_AUIPC) || (opcode == OPC_JAL)) ? pc : rs1_data;
    if ((fmt == FMT_I) || (fmt == FMT_U) || (fmt == FMT_S))
      ctrl.src2 = imm;
    else if (fmt == FMT_SYS)
      ctrl.src2 = csr_data;
    else
      ctrl.src2 = rs2_data;

    ctrl.rd = inst[11:7];
    // ecall saves the pc into mepc
    ctrl.csr_rd    = is_ecall ? CSR_MEPC : csr_src;
    ctrl.reg_wr    = (opcode == OPC_SYSTEM) ? (is_csrrw || is_csrrs) : !(is_store || is_branch);
    ctrl.csr_wr    = is_csrrw || is_csrrs || is_ecall;
    ctrl.csr_wd_pc = is_ecall;

    if (opcode == OPC_LOAD)
      ctrl.wd_sel = WD_LOAD;
    else if ((opcode == OPC_JAL) || (opcode == OPC_JALR))
      ctrl.wd_sel = WD_PC4;
    else if (is_csrrw || is_csrrs)
      ctrl.wd_sel = WD_CSR;
    else
      ctrl.wd_sel = WD_ALU;

    ctrl.mem_rd = (opcode == OPC_LOAD);
    ctrl.mem_wr = is_store;
    case (funct3)
      3'b000:  ctrl.wmask = is_store ? 4'b0001 : 4'b0000;
      3'b001:  ctrl.wmask = is_store ? 4'b0011 : 4'b0000;
      default: ctrl.wmask = is_store ? 4'b1111 : 4'b0000;
    endcase
    // byte, half, word
    ctrl.rsize   = funct3[1:0];
    ctrl.rsigned = (opcode == OPC_LOAD) && !funct3[2] && !funct3[1];
    ctrl.ecall   = is_ecall;
    ctrl.ebreak  = (inst == INST_EBREAK);
  end

  always_comb begin
    if (is_ecall || is_mret)
      pc_sel = PC_CSR;
    else if (is_branch || (opcode == OPC_JAL))
      pc_sel = PC_REL;
    else if (opcode == OPC_JALR)
      pc_sel = PC_JALR;
    else
      pc_sel = PC_SEQ;
  end

endmodule

/* src/inst_latch.sv */
// one-entry holding register; a new capture is refused until execute has taken the entry
`timescale 1ns/10ps

module inst_latch import decode_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          in_valid,
  input  fetch_bundle_t in_bundle,
  output logic          in_ready,
  input  logic          stall,
  input  logic          out_ready,
  output fetch_bundle_t held,
  output logic          full,
  output logic          out_valid,
  output logic          accept
);

  typedef enum logic {
    ST_EMPTY,
    ST_FULL
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   capture;

  assign full     = (state == ST_FULL);
  assign in_ready = (state == ST_EMPTY);
  assign capture  = in_valid && in_ready;

  // held back while a source is still being written
  assign out_valid = full && !stall;
  assign accept    = out_valid && out_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_EMPTY: begin
        if (capture)
          state_nxt = ST_FULL;
      end
      ST_FULL: begin
        if (accept)
          state_nxt = ST_EMPTY;
      end
      default: state_nxt = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_EMPTY;
    end else begin
      state <= state_nxt;
    end
  end

  // payload only, stays put until the next capture
  always_ff @(posedge clk) begin
    if (capture) begin
      held <= in_bundle;
    end
  end

endmodule

/* src/next_pc_unit.sv */
// branch compare uses the decoded src1/src2, so both must carry register data for branches
`timescale 1ns/10ps

module next_pc_unit import rv_isa_pkg::*, decode_pkg::*; (
  input  logic [31:0]  pc,
  input  decode_ctrl_t ctrl,
  input  pc_sel_e      pc_sel,
  input  logic [2:0]   br_funct,
  input  logic         is_branch,
  input  logic [31:0]  csr_data,
  output logic [31:0]  next_pc
);

  logic        eq;
  logic        lt_s;
  logic        lt_u;
  logic        taken;
  logic [31:0] pc_seq;
  logic [31:0] jalr_tgt;

  assign eq   = (ctrl.src1 == ctrl.src2);
  assign lt_s = ($signed(ctrl.src1) < $signed(ctrl.src2));
  assign lt_u = (ctrl.src1 < ctrl.src2);

  always_comb begin
    case (br_funct)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt_s;
      F3_BGE:  taken = !lt_s;
      F3_BLTU: taken = lt_u;
      F3_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign pc_seq   = pc + 32'd4;
  // target lsb forced to zero
  assign jalr_tgt = (ctrl.src1 + ctrl.imm) & ~32'd1;

  always_comb begin
    case (pc_sel)
      PC_REL: begin
        if (is_branch && !taken)
          next_pc = pc_seq;
        else
          next_pc = pc + ctrl.imm;
      end
      PC_JALR: next_pc = jalr_tgt;
      PC_CSR:  next_pc = csr_data;
      default: next_pc = pc_seq;
    endcase
  end

endmodule

/* src/rv_isa_pkg.sv */
// RV32IM plus machine-mode CSRs only; unmapped CSR numbers fall back to mtvec
package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INST_MRET   = 32'h3020_0073;

  localparam logic [11:0] CSR_NUM_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_NUM_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_NUM_MEPC    = 12'h341;
  localparam logic [11:0] CSR_NUM_MCAUSE  = 12'h342;

  typedef enum logic [2:0] {
    FMT_I, FMT_U, FMT_S, FMT_J, FMT_B, FMT_R, FMT_SYS
  } inst_fmt_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_MUL, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
    ALU_IMM, ALU_CSR_SRC, ALU_CSR_OR
  } alu_op_e;

  // local index into the small CSR file
  typedef enum logic [1:0] {
    CSR_MCAUSE, CSR_MEPC, CSR_MSTATUS, CSR_MTVEC
  } csr_idx_e;

  function automatic csr_idx_e csr_map(input logic [11:0] num);
    case (num)
      CSR_NUM_MCAUSE:  return CSR_MCAUSE;
      CSR_NUM_MEPC:    return CSR_MEPC;
      CSR_NUM_MSTATUS: return CSR_MSTATUS;
      CSR_NUM_MTVEC:   return CSR_MTVEC;
      default:         return CSR_MTVEC;
    endcase
  endfunction

endpackage

/* testbench/decode_chk.sv */
// handshake and reset properties of decode_stage; n_fired counts failures for the testbench
`timescale 1ns/10ps

module decode_chk import decode_pkg::*; (
  input logic         clk,
  input logic         rst,
  input logic         in_valid,
  input logic         in_ready,
  input logic         out_valid,
  input logic         out_ready,
  input logic         pc_write,
  input decode_ctrl_t ctrl,
  input logic [31:0]  next_pc,
  input logic [31:0]  pc
);

  int n_fired = 0;

  a_reset_idle: assert property (@(posedge clk) rst |=> (!out_valid && in_ready && !pc_write))
    else begin
      n_fired = n_fired + 1;
      $error("stage not idle after a reset cycle");
    end

  // a captured entry blocks fetch until its transfer
  a_full_blocks: assert property (@(posedge clk) disable iff (rst)
    ((in_valid && in_ready) || (!in_ready && !pc_write)) |=> !in_ready)
    else begin
      n_fired = n_fired + 1;
      $error("in_ready rose before the held entry was transferred");
    end

  // execute holding off must freeze the whole output bundle
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(ctrl) && $stable(next_pc) && $stable(pc)))
    else begin
      n_fired = n_fired + 1;
      $error("outputs changed while execute held them");
    end

  // one pulse per transfer, and the transfer frees the latch
  a_pc_write: assert property (@(posedge clk) disable iff (rst)
    pc_write |=> (in_ready && !pc_write))
    else begin
      n_fired = n_fired + 1;
      $error("pc_write was not a single pulse that emptied the latch");
    end

endmodule

bind decode_stage decode_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .pc_write  (pc_write),
  .ctrl      (ctrl),
  .next_pc   (next_pc),
  .pc        (pc)
);

/* testbench/trace_entry.svh */
// one trace line is 256 bits; the tag field is the raw dest_tag_t and only tag slot 0 is driven
`ifndef TRACE_ENTRY_SVH
`define TRACE_ENTRY_SVH

typedef struct packed {
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] csr_data;
  logic [2:0]  tag_pad;
  // busy, rd, csr_rd, csr_wr
  logic [8:0]  tag;
  logic [7:0]  clr_cycles;
  logic [7:0]  alu_op;
  logic [31:0] imm;
  logic [31:0] next_pc;
  logic        reg_wr;
  logic        csr_wr;
  logic        stall;
  logic        csr_wd_pc;
} trace_entry_t;

`endif

/* testbench/decode_monitor.sv */
// one test in flight at a time; start marks the capture edge of a new trace line
`timescale 1ns/10ps
`include "trace_entry.svh"

module decode_monitor import rv_isa_pkg::*, decode_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  int           test_id,
  input  trace_entry_t exp_entry,
  input  logic         in_ready,
  input  logic         out_valid,
  input  logic         out_ready,
  input  decode_ctrl_t ctrl,
  input  logic [31:0]  next_pc,
  input  logic         pc_write,
  input  logic [4:0]   rs1_addr,
  input  logic [4:0]   rs2_addr,
  input  csr_idx_e     csr_src,
  input  logic [31:0]  pc,
  output logic         done,
  output int           n_pass,
  output int           n_fail
);

  int           errs = 0;
  int           pulses = 0;
  logic         stall_seen = 1'b0;
  logic         holding = 1'b0;
  decode_ctrl_t ctrl_prev;
  logic [31:0]  npc_prev;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t: test %0d %s got %h expected %h",
               $time, test_id, what, got, want);
      errs++;
    end
  endtask

  // ecall reads the trap cause, mret the return address
  function automatic csr_idx_e expected_csr_src(input logic [31:0] inst);
    if (inst == 32'h0000_0073)
      return CSR_MCAUSE;
    if (inst == 32'h3020_0073)
      return CSR_MEPC;
    case (inst[31:20])
      12'h300: return CSR_MSTATUS;
      12'h341: return CSR_MEPC;
      12'h342: return CSR_MCAUSE;
      default: return CSR_MTVEC;
    endcase
  endfunction

  always @(posedge clk) begin
    done <= 1'b0;
    if (rst) begin
      n_pass = 0;
      n_fail = 0;
    end else if (start) begin
      errs       = 0;
      pulses     = 0;
      stall_seen = 1'b0;
      holding    = 1'b0;
    end else begin
      // full but held back
      if (!in_ready && !out_valid)
        stall_seen = 1'b1;
      if (holding && ((ctrl != ctrl_prev) || (next_pc != npc_prev))) begin
        $display("Mismatch at %0t: test %0d outputs changed while held", $time, test_id);
        errs++;
      end
      holding   = out_valid && !out_ready;
      ctrl_prev = ctrl;
      npc_prev  = next_pc;
      if (pc_write)
        pulses++;
      if (out_valid && out_ready) begin
        check_value("alu_op", {27'd0, ctrl.alu_op}, {27'd0, exp_entry.alu_op[4:0]});
        check_value("imm", ctrl.imm, exp_entry.imm);
        check_value("next_pc", next_pc, exp_entry.next_pc);
        check_value("reg_wr", {31'd0, ctrl.reg_wr}, {31'd0, exp_entry.reg_wr});
        check_value("csr_wr", {31'd0, ctrl.csr_wr}, {31'd0, exp_entry.csr_wr});
        check_value("csr_wd_pc", {31'd0, ctrl.csr_wd_pc}, {31'd0, exp_entry.csr_wd_pc});
        check_value("stall", {31'd0, stall_seen}, {31'd0, exp_entry.stall});
        check_value("pc_write pulses", pulses, 32'd1);
        check_value("pc", pc, exp_entry.pc);
        // register addresses sit in the rs1 and rs2 fields
        check_value("rs1_addr", {27'd0, rs1_addr}, {27'd0, exp_entry.inst[19:15]});
        check_value("rs2_addr", {27'd0, rs2_addr}, {27'd0, exp_entry.inst[24:20]});
        if (exp_entry.inst[6:0] == 7'b1110011)
          check_value("csr_src", {30'd0, csr_src},
                      {30'd0, expected_csr_src(exp_entry.inst)});
        if (errs == 0) begin
          $display("test %0d passed", test_id);
          n_pass++;
        end else begin
          $display("test %0d failed with %0d errors", test_id, errs);
          n_fail++;
        end
        done <= 1'b1;
      end
    end
  end

endmodule

/* testbench/decode_trace.txt */
// inst_pc_rs1data_rs2data_csrdata_tag(12b)_clrcycles_aluop_imm_nextpc_flags
// flags = {reg_wr, csr_wr, stall expected, csr_wd_pc}
FFB10093_00000100_00000010_00000020_00000000_000_00_00_FFFFFFFB_00000104_8
123452B7_00000100_00000000_00000000_00000000_000_00_10_12345000_00000104_8
00312423_00000100_00000010_00000020_00000000_000_00_00_00000008_00000104_0
FF1FF0EF_00000200_00000000_00000000_00000000_000_00_00_FFFFFFF0_000001F0_8
00208463_00000100_00000005_00000005_00000000_000_00_01_00000008_00000108_0
00209463_00000100_00000005_00000005_00000000_000_00_01_00000008_00000104_0
0020C463_00000100_FFFFFFFF_00000001_00000000_000_00_08_00000008_00000108_0
0020D463_00000100_FFFFFFFF_00000001_00000000_000_00_08_00000008_00000104_0
0020E463_00000100_FFFFFFFF_00000001_00000000_000_00_09_00000008_00000104_0
0020F463_00000100_FFFFFFFF_00000001_00000000_000_00_09_00000008_00000108_0
30521173_00000100_00000055_00000000_0000ABCD_000_00_11_00000305_00000104_C
3003A373_00000100_00000055_00000000_0000ABCD_000_00_12_00000300_00000104_C
00000073_00000100_00000000_00000000_00000800_000_00_00_00000000_00000800_5
30200073_00000100_00000000_00000000_00001234_000_00_00_00000302_00001234_0
005100E7_00000100_00001000_00000000_00000000_000_00_00_00000005_00001004_8
002081B3_00000100_00000001_00000002_00000000_108_04_00_00000000_00000104_A
402081B3_00000100_00000001_00000002_00000000_100_04_01_00000000_00000104_8
40335293_00000100_00000080_00000000_00000000_000_00_07_00000403_00000104_8
00335293_00000100_00000080_00000000_00000000_000_00_06_00000003_00000104_8
022081B3_00000100_00000003_00000004_00000000_000_00_0A_00000000_00000104_8
0220D1B3_00000100_00000009_00000003_00000000_000_00_0D_00000000_00000104_8
3413A373_00000100_00000007_00000000_00000001_103_03_12_00000341_00000104_E

/* testbench/tb_decode.sv */
// runs the trace lines one by one; only tag slot 0 is used and the trace sets its clear time
`timescale 1ns/10ps
`include "trace_entry.svh"

module tb_decode import rv_isa_pkg::*, decode_pkg::*; ();

  localparam int N_STAGES = 3;
  localparam int N_TESTS  = 22;
  localparam int TIMEOUT  = 200;

  logic          clk = 1'b0;
  logic          rst;
  logic          in_valid;
  fetch_bundle_t in_bundle;
  logic          in_ready;
  dest_tag_t     tags [N_STAGES];
  logic [4:0]    rs1_addr;
  logic [4:0]    rs2_addr;
  csr_idx_e      csr_src;
  logic [31:0]   rs1_data;
  logic [31:0]   rs2_data;
  logic [31:0]   csr_data;
  logic          out_valid;
  logic          out_ready;
  decode_ctrl_t  ctrl;
  logic [31:0]   pc;
  logic [31:0]   next_pc;
  logic          pc_write;

  logic [255:0]  trace_mem [N_TESTS];
  trace_entry_t  exp_entry;
  logic          start;
  int            test_id;
  logic          done;
  int            n_pass;
  int            n_fail;
  bit            timed_out;

  always #20 clk = ~clk;

  decode_stage #(
    .N_STAGES (N_STAGES)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_bundle (in_bundle),
    .in_ready  (in_ready),
    .tags      (tags),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .csr_src   (csr_src),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .csr_data  (csr_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .ctrl      (ctrl),
    .pc        (pc),
    .next_pc   (next_pc),
    .pc_write  (pc_write)
  );

  decode_monitor u_monitor (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .test_id   (test_id),
    .exp_entry (exp_entry),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .ctrl      (ctrl),
    .next_pc   (next_pc),
    .pc_write  (pc_write),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .csr_src   (csr_src),
    .pc        (pc),
    .done      (done),
    .n_pass    (n_pass),
    .n_fail    (n_fail)
  );

  // sel 0 in_ready, 1 out_valid, otherwise the monitor's done
  task automatic wait_for(input int sel, input int test, input string what, output bit ok);
    int   cycles;
    logic level;
    cycles = 0;
    ok = 1'b0;
    while (!ok && (cycles < TIMEOUT)) begin
      @(posedge clk);
      cycles++;
      case (sel)
        0:       level = in_ready;
        1:       level = out_valid;
        default: level = done;
      endcase
      ok = (level === 1'b1);
    end
    if (!ok)
      $display("Timeout: test %0d never saw %s within %0d cycles", test, what, TIMEOUT);
  endtask

  initial begin
    bit           ok;
    trace_entry_t t;
    int           holdoff;
    void'($urandom(32'hc0a4_b862));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_bundle = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    csr_data  = '0;
    out_ready = 1'b0;
    start     = 1'b0;
    test_id   = 0;
    exp_entry = '0;
    timed_out = 1'b0;
    for (int i = 0; i < N_STAGES; i++)
      tags[i] = '0;
    $readmemh("testbench/decode_trace.txt", trace_mem);
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_TESTS; i++) begin
      t = trace_entry_t'(trace_mem[i]);
      holdoff = int'($urandom % 32'd4);
      wait_for(0, i, "in_ready", ok);
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
      in_valid  <= 1'b1;
      in_bundle <= {t.inst, t.pc};
      rs1_data  <= t.rs1_data;
      rs2_data  <= t.rs2_data;
      csr_data  <= t.csr_data;
      tags[0]   <= dest_tag_t'(t.tag);
      exp_entry <= t;
      test_id   <= i;
      start     <= 1'b1;
      @(posedge clk);
      in_valid <= 1'b0;
      start    <= 1'b0;
      // in-flight writer retires after the traced number of cycles
      repeat (t.clr_cycles) @(posedge clk);
      tags[0] <= '0;
      wait_for(1, i, "out_valid", ok);
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
      repeat (holdoff) @(posedge clk);
      out_ready <= 1'b1;
      wait_for(2, i, "the transfer", ok);
      out_ready <= 1'b0;
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
    end

    repeat (2) @(posedge clk);
    $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
             N_TESTS, n_pass, n_fail, DUT.u_chk.n_fired);
    if (!timed_out && (n_fail == 0) && (n_pass == N_TESTS) && (DUT.u_chk.n_fired == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
